// File: vlog.f
hdl/noc_geom_pkg.sv
hdl/swa_types_pkg.sv
hdl/rr_arbiter.sv
hdl/sep_sw_alloc.sv
hdl/spec_sw_alloc.sv
hdl/ovc_grant_alloc.sv
hdl/comb_spec_allocator.sv
tb/comb_spec_allocator_sva.sv
tb/tb_comb_spec_allocator.sv

// File: tb/tb_comb_spec_allocator.sv
`timescale 1ns/1ps
`default_nettype none

module tb_comb_spec_allocator;

    import noc_geom_pkg::*;
    import swa_types_pkg::*;

    localparam int RESET_CYCLES = 5;
    localparam int FAIR_CYCLES  = 3 * V;
    localparam int RAND_CYCLES  = 400;
    // fairness, random and one idle cycle all fit inside this
    localparam int TIMEOUT_CYCLES = 500;
    localparam int DRIVE_DELAY  = 2;
    localparam logic [31:0] SEED = 32'h73e3;

    logic      clk;
    logic      rst_n;
    vc_vec_t   ivc_request           [P];
    vc_vec_t   ovc_is_assigned       [P];
    vc_vec_t   assigned_ovc_not_full [P];
    port_sel_t dest_port             [P][V];
    vc_vec_t   candidate_ovc         [P][V];
    vc_vec_t   ivc_sw_granted        [P];
    port_sel_t granted_dest_port     [P];
    vc_vec_t   ivc_ovc_granted       [P];
    vc_vec_t   granted_ovc_num       [P];
    vc_vec_t   ovc_allocated         [P];

    // cycles since reset release
    int unsigned cycle_count = 0;

    comb_spec_allocator comb_spec_allocator_inst (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .ivc_request           (ivc_request),
        .ovc_is_assigned       (ovc_is_assigned),
        .assigned_ovc_not_full (assigned_ovc_not_full),
        .dest_port             (dest_port),
        .candidate_ovc         (candidate_ovc),
        .ivc_sw_granted        (ivc_sw_granted),
        .granted_dest_port     (granted_dest_port),
        .ivc_ovc_granted       (ivc_ovc_granted),
        .granted_ovc_num       (granted_ovc_num),
        .ovc_allocated         (ovc_allocated)
    );

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        if (rst_n) begin
            cycle_count <= cycle_count + 1;
        end
    end

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("TESTS FAILED");
        $fatal(1, "timeout, run did not finish within %0d cycles after reset", TIMEOUT_CYCLES);
    end

    // stop at the first assertion failure
    initial begin
        wait (comb_spec_allocator_inst.sva_inst.fail_count != 0);
        $display("TESTS FAILED");
        $fatal(1, "an allocator assertion failed");
    end

    task automatic clear_inputs();
        for (int i = 0; i < P; i++) begin
            ivc_request[i] = '0;
            ovc_is_assigned[i] = '0;
            assigned_ovc_not_full[i] = '0;
            for (int v = 0; v < V; v++) begin
                dest_port[i][v] = '0;
                candidate_ovc[i][v] = '0;
            end
        end
    endtask

    // one-hot dest, candidates only for vcs without an ovc
    task automatic drive_random();
        for (int i = 0; i < P; i++) begin
            ivc_request[i] = vc_vec_t'($urandom);
            ovc_is_assigned[i] = vc_vec_t'($urandom);
            assigned_ovc_not_full[i] = vc_vec_t'($urandom);
            for (int v = 0; v < V; v++) begin
                dest_port[i][v] = port_sel_t'(1) << ($urandom % P_1);
                candidate_ovc[i][v] = ovc_is_assigned[i][v] ? '0 : vc_vec_t'($urandom);
            end
        end
    endtask

    // first requester at or after the pointer
    function automatic int rr_pick(input vc_vec_t req, input int ptr);
        int idx;
        for (int off = 0; off < V; off++) begin
            idx = (ptr + off) % V;
            if (req[idx]) begin
                return idx;
            end
        end
        return -1;
    endfunction

    // -1 when not one-hot
    function automatic int vc_index(input vc_vec_t grant);
        if (!$onehot(grant)) begin
            return -1;
        end
        for (int v = 0; v < V; v++) begin
            if (grant[v]) begin
                return v;
            end
        end
        return -1;
    endfunction

    task automatic check_value(input string test_name, input int expected, input int actual);
        if (expected != actual) begin
            $display("FAILED %s expected %0d actual %0d", test_name, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "wrong value in %s", test_name);
        end
    endtask

    // port 0 only, all vcs owning a never-full ovc, distinct outputs
    task automatic run_fairness();
        int exp_ptr;
        int expected;
        int actual;
        exp_ptr = 0;
        clear_inputs();
        ivc_request[0] = '1;
        ovc_is_assigned[0] = '1;
        assigned_ovc_not_full[0] = '1;
        for (int v = 0; v < V; v++) begin
            dest_port[0][v] = port_sel_t'(1) << (v % P_1);
        end
        for (int c = 0; c < FAIR_CYCLES; c++) begin
            @(negedge clk);
            expected = rr_pick(ivc_request[0], exp_ptr);
            actual = vc_index(ivc_sw_granted[0]);
            check_value("rr_fairness", expected, actual);
            exp_ptr = (expected + 1) % V;
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    task automatic run_random();
        for (int c = 0; c < RAND_CYCLES; c++) begin
            drive_random();
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n = 1'b0;
        clear_inputs();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        run_fairness();
        run_random();
        // one idle cycle with all requests cleared
        clear_inputs();
        @(posedge clk);
        #1;
        if (comb_spec_allocator_inst.sva_inst.fail_count == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("TESTS FAILED");
            $fatal(1, "allocator assertions failed during the run");
        end
    end

endmodule

`default_nettype wire

// File: tb/comb_spec_allocator_sva.sv
`timescale 1ns/1ps
`default_nettype none

module comb_spec_allocator_sva (
    input wire                       clk,
    input wire                       rst_n,
    input swa_types_pkg::vc_vec_t    ivc_request           [noc_geom_pkg::P],
    input swa_types_pkg::vc_vec_t    ovc_is_assigned       [noc_geom_pkg::P],
    input swa_types_pkg::vc_vec_t    assigned_ovc_not_full [noc_geom_pkg::P],
    input swa_types_pkg::port_sel_t  dest_port     [noc_geom_pkg::P][noc_geom_pkg::V],
    input swa_types_pkg::vc_vec_t    candidate_ovc [noc_geom_pkg::P][noc_geom_pkg::V],
    input swa_types_pkg::vc_vec_t    ivc_sw_granted        [noc_geom_pkg::P],
    input swa_types_pkg::port_sel_t  granted_dest_port     [noc_geom_pkg::P],
    input swa_types_pkg::vc_vec_t    ivc_ovc_granted       [noc_geom_pkg::P],
    input swa_types_pkg::vc_vec_t    granted_ovc_num       [noc_geom_pkg::P],
    input swa_types_pkg::vc_vec_t    ovc_allocated         [noc_geom_pkg::P]
);

    import noc_geom_pkg::*;
    import swa_types_pkg::*;

    // count of failed assertions
    int unsigned fail_count = 0;

    // inputs using each output port
    int unsigned out_users  [P];
    // dest and candidates of the granted vc
    port_sel_t   exp_dest   [P];
    vc_vec_t     grant_cand [P];
    // ovc bits expected at each output
    vc_vec_t     exp_alloc  [P];
    logic        nonspec_pending;
    logic        nonspec_won;

    // destination bit k of input i to output index
    function automatic int out_of(input int i, input int k);
        return (k < i) ? k : k + 1;
    endfunction

    always_comb begin
        nonspec_pending = 1'b0;
        nonspec_won = 1'b0;
        for (int o = 0; o < P; o++) begin
            out_users[o] = 0;
            exp_alloc[o] = '0;
        end
        for (int i = 0; i < P; i++) begin
            exp_dest[i] = '0;
            grant_cand[i] = '0;
            for (int v = 0; v < V; v++) begin
                if (ivc_sw_granted[i][v]) begin
                    exp_dest[i] = exp_dest[i] | dest_port[i][v];
                    grant_cand[i] = grant_cand[i] | candidate_ovc[i][v];
                end
            end
            // owned ovc with room and a flit waiting
            if (|(ivc_request[i] & ovc_is_assigned[i] & assigned_ovc_not_full[i])) begin
                nonspec_pending = 1'b1;
            end
            if (|(ivc_sw_granted[i] & ovc_is_assigned[i])) begin
                nonspec_won = 1'b1;
            end
            for (int k = 0; k < P_1; k++) begin
                if (granted_dest_port[i][k]) begin
                    out_users[out_of(i, k)] = out_users[out_of(i, k)] + 1;
                    if (|ivc_ovc_granted[i]) begin
                        exp_alloc[out_of(i, k)] = exp_alloc[out_of(i, k)] | granted_ovc_num[i];
                    end
                end
            end
        end
    end

    for (genvar i = 0; i < P; i++) begin : g_in
        one_grant_per_input: assert property (@(posedge clk) disable iff (!rst_n)
            $onehot0(ivc_sw_granted[i]) && (ivc_sw_granted[i] & ~ivc_request[i]) == '0)
        else begin
            fail_count++;
            $error("input %0d has more than one vc grant or a grant without request", i);
        end

        // destination one-hot and matching the granted vc
        dest_matches_vc: assert property (@(posedge clk) disable iff (!rst_n)
            granted_dest_port[i] == exp_dest[i]
            && ((ivc_sw_granted[i] != '0) == $onehot(granted_dest_port[i])))
        else begin
            fail_count++;
            $error("input %0d granted destination does not match its vc", i);
        end

        ovc_grant_matches: assert property (@(posedge clk) disable iff (!rst_n)
            ivc_ovc_granted[i] == (ivc_sw_granted[i] & ~ovc_is_assigned[i])
            && ((ivc_ovc_granted[i] != '0) ?
                ($onehot(granted_ovc_num[i]) && (granted_ovc_num[i] & ~grant_cand[i]) == '0) :
                (granted_ovc_num[i] == '0)))
        else begin
            fail_count++;
            $error("input %0d ovc grant wrong or outside its candidates", i);
        end
    end

    for (genvar o = 0; o < P; o++) begin : g_out
        output_conflict_free: assert property (@(posedge clk) disable iff (!rst_n)
            out_users[o] <= 1 && ovc_allocated[o] == exp_alloc[o])
        else begin
            fail_count++;
            $error("output %0d shared by inputs or wrong ovc marked allocated", o);
        end
    end

    nonspec_progress: assert property (@(posedge clk) disable iff (!rst_n)
        nonspec_pending |-> nonspec_won)
    else begin
        fail_count++;
        $error("non-speculative request pending but no non-speculative grant");
    end

endmodule

bind comb_spec_allocator comb_spec_allocator_sva sva_inst (.*);

`default_nettype wire

// File: hdl/comb_spec_allocator.sv
`timescale 1ns/1ps
`default_nettype none

module comb_spec_allocator (
    input  wire                        clk,
    input  wire                        rst_n,
    input  swa_types_pkg::vc_vec_t     ivc_request           [noc_geom_pkg::P],
    input  swa_types_pkg::vc_vec_t     ovc_is_assigned       [noc_geom_pkg::P],
    input  swa_types_pkg::vc_vec_t     assigned_ovc_not_full [noc_geom_pkg::P],
    input  swa_types_pkg::port_sel_t   dest_port     [noc_geom_pkg::P][noc_geom_pkg::V],
    input  swa_types_pkg::vc_vec_t     candidate_ovc [noc_geom_pkg::P][noc_geom_pkg::V],
    output swa_types_pkg::vc_vec_t     ivc_sw_granted        [noc_geom_pkg::P],
    output swa_types_pkg::port_sel_t   granted_dest_port     [noc_geom_pkg::P],
    output swa_types_pkg::vc_vec_t     ivc_ovc_granted       [noc_geom_pkg::P],
    output swa_types_pkg::vc_vec_t     granted_ovc_num       [noc_geom_pkg::P],
    output swa_types_pkg::vc_vec_t     ovc_allocated         [noc_geom_pkg::P]
);

    import noc_geom_pkg::*;
    import swa_types_pkg::*;

    // surviving spec grants, switch stage to ovc stage
    wire vc_vec_t   spec_granted_ivc       [P];
    wire port_sel_t spec_granted_dest_port [P];

    spec_sw_alloc spec_sw_alloc_inst (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .ivc_request            (ivc_request),
        .ovc_is_assigned        (ovc_is_assigned),
        .assigned_ovc_not_full  (assigned_ovc_not_full),
        .dest_port              (dest_port),
        .candidate_ovc          (candidate_ovc),
        .ivc_sw_granted         (ivc_sw_granted),
        .granted_dest_port      (granted_dest_port),
        .spec_granted_ivc       (spec_granted_ivc),
        .spec_granted_dest_port (spec_granted_dest_port)
    );

    ovc_grant_alloc ovc_grant_alloc_inst (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .spec_granted_ivc       (spec_granted_ivc),
        .spec_granted_dest_port (spec_granted_dest_port),
        .candidate_ovc          (candidate_ovc),
        .ivc_ovc_granted        (ivc_ovc_granted),
        .granted_ovc_num        (granted_ovc_num),
        .ovc_allocated          (ovc_allocated)
    );

endmodule

`default_nettype wire

// File: hdl/ovc_grant_alloc.sv
`timescale 1ns/1ps
`default_nettype none

module ovc_grant_alloc (
    input  wire                        clk,
    input  wire                        rst_n,
    input  swa_types_pkg::vc_vec_t     spec_granted_ivc       [noc_geom_pkg::P],
    input  swa_types_pkg::port_sel_t   spec_granted_dest_port [noc_geom_pkg::P],
    input  swa_types_pkg::vc_vec_t     candidate_ovc [noc_geom_pkg::P][noc_geom_pkg::V],
    output swa_types_pkg::vc_vec_t     ivc_ovc_granted        [noc_geom_pkg::P],
    output swa_types_pkg::vc_vec_t     granted_ovc_num        [noc_geom_pkg::P],
    output swa_types_pkg::vc_vec_t     ovc_allocated          [noc_geom_pkg::P]
);

    import noc_geom_pkg::*;
    import swa_types_pkg::*;

    // candidate mask of the accepted spec vc
    vc_vec_t   ovc_req   [P];
    vc_vec_t   ovc_grant [P];
    port_vec_t ovc_any;

    for (genvar i = 0; i < P; i++) begin : g_port
        // zero when no spec grant survived at this port
        always_comb begin
            ovc_req[i] = '0;
            for (int v = 0; v < V; v++) begin
                if (spec_granted_ivc[i][v]) begin
                    ovc_req[i] = ovc_req[i] | candidate_ovc[i][v];
                end
            end
        end

        // pick one free ovc for the winner
        rr_arbiter #(
            .WIDTH (V)
        ) ovc_arb (
            .clk       (clk),
            .rst_n     (rst_n),
            .request   (ovc_req[i]),
            .grant     (ovc_grant[i]),
            .any_grant (ovc_any[i])
        );

        assign ivc_ovc_granted[i] = ovc_any[i] ? spec_granted_ivc[i] : '0;
        assign granted_ovc_num[i] = ovc_grant[i];
    end

    // chosen ovc marked at the output it belongs to
    // at most one input targets a given output
    always_comb begin
        for (int o = 0; o < P; o++) begin
            ovc_allocated[o] = '0;
            for (int i = 0; i < P; i++) begin
                if (o < i && spec_granted_dest_port[i][o]) begin
                    ovc_allocated[o] = ovc_allocated[o] | ovc_grant[i];
                end else if (o > i && spec_granted_dest_port[i][o-1]) begin
                    ovc_allocated[o] = ovc_allocated[o] | ovc_grant[i];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/spec_sw_alloc.sv
`timescale 1ns/1ps
`default_nettype none

module spec_sw_alloc (
    input  wire                        clk,
    input  wire                        rst_n,
    input  swa_types_pkg::vc_vec_t     ivc_request            [noc_geom_pkg::P],
    input  swa_types_pkg::vc_vec_t     ovc_is_assigned        [noc_geom_pkg::P],
    input  swa_types_pkg::vc_vec_t     assigned_ovc_not_full  [noc_geom_pkg::P],
    input  swa_types_pkg::port_sel_t   dest_port     [noc_geom_pkg::P][noc_geom_pkg::V],
    input  swa_types_pkg::vc_vec_t     candidate_ovc [noc_geom_pkg::P][noc_geom_pkg::V],
    output swa_types_pkg::vc_vec_t     ivc_sw_granted         [noc_geom_pkg::P],
    output swa_types_pkg::port_sel_t   granted_dest_port      [noc_geom_pkg::P],
    output swa_types_pkg::vc_vec_t     spec_granted_ivc       [noc_geom_pkg::P],
    output swa_types_pkg::port_sel_t   spec_granted_dest_port [noc_geom_pkg::P]
);

    import noc_geom_pkg::*;
    import swa_types_pkg::*;

    vc_vec_t   nonspec_req      [P];
    vc_vec_t   spec_req         [P];
    vc_vec_t   nonspec_ivc      [P];
    vc_vec_t   spec_ivc_pre     [P];
    port_sel_t nonspec_dest     [P];
    port_sel_t spec_dest_pre    [P];
    // nonspec output grants seen from each input port
    port_sel_t nonspec_out_view [P];
    port_vec_t nonspec_inport;
    port_vec_t nonspec_outport;

    // owned ovc with room goes nonspec
    // no ovc but some candidate goes spec
    always_comb begin
        for (int i = 0; i < P; i++) begin
            nonspec_req[i] = ivc_request[i] & ovc_is_assigned[i] & assigned_ovc_not_full[i];
            spec_req[i] = ivc_request[i] & ~ovc_is_assigned[i];
            for (int v = 0; v < V; v++) begin
                if (candidate_ovc[i][v] == '0) begin
                    spec_req[i][v] = 1'b0;
                end
            end
        end
    end

    sep_sw_alloc nonspec_alloc (
        .clk               (clk),
        .rst_n             (rst_n),
        .request           (nonspec_req),
        .dest_port         (dest_port),
        .ivc_granted       (nonspec_ivc),
        .granted_dest_port (nonspec_dest),
        .inport_granted    (nonspec_inport),
        .outport_granted   (nonspec_outport)
    );

    // runs in parallel with nonspec_alloc
    // its own port usage is not needed
    sep_sw_alloc spec_alloc (
        .clk               (clk),
        .rst_n             (rst_n),
        .request           (spec_req),
        .dest_port         (dest_port),
        .ivc_granted       (spec_ivc_pre),
        .granted_dest_port (spec_dest_pre),
        .inport_granted    (),
        .outport_granted   ()
    );

    always_comb begin
        for (int i = 0; i < P; i++) begin
            nonspec_out_view[i] = '0;
            for (int o = 0; o < P; o++) begin
                if (o < i) begin
                    nonspec_out_view[i][o] = nonspec_outport[o];
                end else if (o > i) begin
                    nonspec_out_view[i][o-1] = nonspec_outport[o];
                end
            end
            // spec grant dies if nonspec took its input or its output
            spec_granted_dest_port[i] = nonspec_inport[i] ? '0 :
                                        spec_dest_pre[i] & ~nonspec_out_view[i];
            spec_granted_ivc[i] = (|spec_granted_dest_port[i]) ? spec_ivc_pre[i] : '0;
            // the two grant sets never overlap
            ivc_sw_granted[i] = nonspec_ivc[i] | spec_granted_ivc[i];
            granted_dest_port[i] = nonspec_dest[i] | spec_granted_dest_port[i];
        end
    end

endmodule

`default_nettype wire

// File: hdl/sep_sw_alloc.sv
`timescale 1ns/1ps
`default_nettype none

module sep_sw_alloc (
    input  wire                        clk,
    input  wire                        rst_n,
    input  swa_types_pkg::vc_vec_t     request           [noc_geom_pkg::P],
    input  swa_types_pkg::port_sel_t   dest_port         [noc_geom_pkg::P][noc_geom_pkg::V],
    output swa_types_pkg::vc_vec_t     ivc_granted       [noc_geom_pkg::P],
    output swa_types_pkg::port_sel_t   granted_dest_port [noc_geom_pkg::P],
    output swa_types_pkg::port_vec_t   inport_granted,
    output swa_types_pkg::port_vec_t   outport_granted
);

    import noc_geom_pkg::*;
    import swa_types_pkg::*;

    // winner of each input arbiter
    vc_vec_t   first_grant [P];
    // destination of that winner
    port_sel_t sel_dest    [P];
    // requests seen by each output arbiter, indexed by input
    port_sel_t out_req     [P];
    port_sel_t out_grant   [P];

    for (genvar i = 0; i < P; i++) begin : g_in_port
        // first stage picks one vc per input port
        rr_arbiter #(
            .WIDTH (V)
        ) input_arb (
            .clk       (clk),
            .rst_n     (rst_n),
            .request   (request[i]),
            .grant     (first_grant[i]),
            .any_grant ()
        );

        // one-hot mux of the winner's destination
        always_comb begin
            sel_dest[i] = '0;
            for (int v = 0; v < V; v++) begin
                if (first_grant[i][v]) begin
                    sel_dest[i] = sel_dest[i] | dest_port[i][v];
                end
            end
        end
    end

    // input view to output view
    always_comb begin
        for (int o = 0; o < P; o++) begin
            out_req[o] = '0;
            for (int i = 0; i < P; i++) begin
                if (i < o) begin
                    out_req[o][i] = sel_dest[i][o-1];
                end else if (i > o) begin
                    out_req[o][i-1] = sel_dest[i][o];
                end
            end
        end
    end

    for (genvar o = 0; o < P; o++) begin : g_out_port
        // second stage picks one input port per output
        rr_arbiter #(
            .WIDTH (P_1)
        ) output_arb (
            .clk       (clk),
            .rst_n     (rst_n),
            .request   (out_req[o]),
            .grant     (out_grant[o]),
            .any_grant (outport_granted[o])
        );
    end

    // output grants mapped back to each input's view
    always_comb begin
        for (int i = 0; i < P; i++) begin
            granted_dest_port[i] = '0;
            for (int o = 0; o < P; o++) begin
                if (o < i) begin
                    granted_dest_port[i][o] = out_grant[o][i-1];
                end else if (o > i) begin
                    granted_dest_port[i][o-1] = out_grant[o][i];
                end
            end
            // vc grant holds only if its output was won
            inport_granted[i] = |granted_dest_port[i];
            ivc_granted[i] = inport_granted[i] ? first_grant[i] : '0;
        end
    end

endmodule

`default_nettype wire

// File: hdl/rr_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter #(
    parameter int WIDTH = 4
) (
    input  wire              clk,
    input  wire              rst_n,
    input  wire  [WIDTH-1:0] request,
    output logic [WIDTH-1:0] grant,
    output logic             any_grant
);

    localparam int PTR_W = (WIDTH > 1) ? $clog2(WIDTH) : 1;

    // index holding highest priority this cycle
    logic [PTR_W-1:0] ptr;
    logic [PTR_W-1:0] win_idx;
    logic             found;

    // scan from the pointer, wrapping around
    always_comb begin
        grant = '0;
        win_idx = '0;
        found = 1'b0;
        for (int off = 0; off < WIDTH; off++) begin
            if (!found && request[(int'(ptr) + off) % WIDTH]) begin
                found = 1'b1;
                win_idx = PTR_W'((int'(ptr) + off) % WIDTH);
            end
        end
        if (found) begin
            grant[win_idx] = 1'b1;
        end
    end

    assign any_grant = found;

    // next search starts just after the winner
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (found) begin
            ptr <= (win_idx == PTR_W'(WIDTH - 1)) ? '0 : win_idx + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/swa_types_pkg.sv
`default_nettype none

// vector types passed between the allocator blocks
package swa_types_pkg;

    import noc_geom_pkg::*;

    // one bit per vc of a port
    // requests, grants and ovc masks all use this
    typedef logic [V-1:0] vc_vec_t;

    // one-hot destination among the other ports
    // for input port i, bit k is output k when k < i,
    // otherwise output k+1
    typedef logic [P_1-1:0] port_sel_t;

    // one bit per router port
    typedef logic [P-1:0] port_vec_t;

endpackage

`default_nettype wire

// File: hdl/noc_geom_pkg.sv
`default_nettype none

// router geometry seen by every allocator block
package noc_geom_pkg;

    // ports per router, local port included
    localparam int P = 5;

    // virtual channels per port
    localparam int V = 4;

    // a port never routes back to itself,
    // so each input sees P-1 possible outputs
    localparam int P_1 = P - 1;

endpackage

`default_nettype wire
